//--- pipe_core_top.f
rtl/core_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/pipe_core_top.sv
verif/pipe_core_props.sv
verif/commit_checker.sv
verif/pipe_core_tb.sv

//--- rtl/core_pkg.sv
// core_pkg: shared widths, opcodes, ALU operations and stage payloads of the RV32I pipeline
package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;

    localparam xlen_t RESET_PC = 32'h0000_0000;
    localparam xlen_t NOP_INSN = 32'h0000_0013; // addi x0, x0, 0

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B // lui
    } alu_op_e;

    typedef struct packed {
        xlen_t pc;
        xlen_t insn;
    } if_id_t;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    rs1_data;
        xlen_t    rs2_data;
        xlen_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;   // operand b from imm
        logic     is_branch;
        logic     branch_ne; // bne when set, beq otherwise
        logic     is_jal;
        reg_idx_t rd;
        logic     reg_write;
        logic     unknown;
    } id_ex_t;

    // also the commit trace payload
    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        logic     reg_write;
        xlen_t    result;
        logic     unknown;
    } ex_wb_t;

endpackage

//--- rtl/decode_stage.sv
// decode_stage: field decode, immediate generation and operand read into the execute payload
`timescale 1ns/1ps

module decode_stage (
    input  core_pkg::if_id_t   if_id_i,
    input  logic               if_id_valid_i,
    output core_pkg::reg_idx_t rs1_o,
    output core_pkg::reg_idx_t rs2_o,
    input  core_pkg::xlen_t    rs1_data_i,
    input  core_pkg::xlen_t    rs2_data_i,
    output core_pkg::id_ex_t   id_ex_o,
    output logic               id_ex_valid_o
);
    import core_pkg::*;

    xlen_t      insn;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd_field;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_b;
    xlen_t      imm_j;

    assign insn     = if_id_valid_i ? if_id_i.insn : NOP_INSN; // bubbles decode as nop
    assign opcode   = insn[6:0];
    assign funct3   = insn[14:12];
    assign funct7   = insn[31:25];
    assign rd_field = insn[11:7];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    assign rs1_o = insn[19:15];
    assign rs2_o = insn[24:20];

    assign id_ex_valid_o = if_id_valid_i;

    always_comb begin
        id_ex_o          = '0;
        id_ex_o.pc       = if_id_i.pc;
        id_ex_o.rs1      = rs1_o;
        id_ex_o.rs2      = rs2_o;
        id_ex_o.rs1_data = rs1_data_i;
        id_ex_o.rs2_data = rs2_data_i;
        id_ex_o.alu_op   = ALU_ADD;

        case (opcode)
            OPC_OP: begin
                id_ex_o.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: id_ex_o.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: id_ex_o.alu_op = ALU_SUB;
                    {7'h00, 3'b111}: id_ex_o.alu_op = ALU_AND;
                    {7'h00, 3'b110}: id_ex_o.alu_op = ALU_OR;
                    {7'h00, 3'b100}: id_ex_o.alu_op = ALU_XOR;
                    {7'h00, 3'b010}: id_ex_o.alu_op = ALU_SLT;
                    default: begin
                        id_ex_o.reg_write = 1'b0;
                        id_ex_o.unknown   = 1'b1;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin   // addi only
                    id_ex_o.imm       = imm_i;
                    id_ex_o.use_imm   = 1'b1;
                    id_ex_o.reg_write = 1'b1;
                end else begin
                    id_ex_o.unknown = 1'b1;
                end
            end
            OPC_LUI: begin
                id_ex_o.imm       = imm_u;
                id_ex_o.use_imm   = 1'b1;
                id_ex_o.alu_op    = ALU_PASS_B;
                id_ex_o.reg_write = 1'b1;
            end
            OPC_BRANCH: begin
                if (funct3[2:1] == 2'b00) begin  // beq, bne
                    id_ex_o.imm       = imm_b;
                    id_ex_o.is_branch = 1'b1;
                    id_ex_o.branch_ne = funct3[0];
                end else begin
                    id_ex_o.unknown = 1'b1;
                end
            end
            OPC_JAL: begin
                id_ex_o.imm       = imm_j;
                id_ex_o.is_jal    = 1'b1;
                id_ex_o.reg_write = 1'b1;
            end
            default: id_ex_o.unknown = 1'b1;
        endcase

        // x0 is never a destination, and non-writers report rd zero
        if (id_ex_o.reg_write && rd_field != '0) begin
            id_ex_o.rd = rd_field;
        end else begin
            id_ex_o.reg_write = 1'b0;
            id_ex_o.rd        = '0;
        end
    end

endmodule

//--- rtl/execute_stage.sv
// execute_stage: operand forwarding, ALU, branch and jump resolution with redirect
`timescale 1ns/1ps

module execute_stage (
    input  core_pkg::id_ex_t id_ex_i,
    input  logic             id_ex_valid_i,
    input  core_pkg::ex_wb_t fwd_i,
    input  logic             fwd_valid_i,
    output core_pkg::ex_wb_t ex_wb_o,
    output logic             ex_wb_valid_o,
    output logic             redirect_valid_o,
    output core_pkg::xlen_t  redirect_pc_o
);
    import core_pkg::*;

    logic  fwd_hit_a;
    logic  fwd_hit_b;
    xlen_t op_a;
    xlen_t op_b_reg;
    xlen_t op_b;
    xlen_t alu_res;
    logic  taken;

    // older instruction sits in EX/WB this cycle
    assign fwd_hit_a = fwd_valid_i && fwd_i.reg_write && (fwd_i.rd != '0)
                       && (fwd_i.rd == id_ex_i.rs1);
    assign fwd_hit_b = fwd_valid_i && fwd_i.reg_write && (fwd_i.rd != '0)
                       && (fwd_i.rd == id_ex_i.rs2);

    assign op_a     = fwd_hit_a ? fwd_i.result : id_ex_i.rs1_data;
    assign op_b_reg = fwd_hit_b ? fwd_i.result : id_ex_i.rs2_data;
    assign op_b     = id_ex_i.use_imm ? id_ex_i.imm : op_b_reg;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_b;     // pass b for lui
        endcase
    end

    // branches compare register operands, never the immediate
    assign taken = id_ex_i.is_jal
                   || (id_ex_i.is_branch && ((op_a == op_b_reg) != id_ex_i.branch_ne));

    assign redirect_valid_o = id_ex_valid_i && taken;   // doubles as flush of IF/ID, ID/EX
    assign redirect_pc_o    = id_ex_i.pc + id_ex_i.imm;

    assign ex_wb_valid_o = id_ex_valid_i;

    always_comb begin
        ex_wb_o           = '0;
        ex_wb_o.pc        = id_ex_i.pc;
        ex_wb_o.rd        = id_ex_i.rd;
        ex_wb_o.reg_write = id_ex_i.reg_write;
        ex_wb_o.unknown   = id_ex_i.unknown;
        if (id_ex_i.reg_write) begin
            ex_wb_o.result = id_ex_i.is_jal ? id_ex_i.pc + XLEN'(4) : alu_res; // link addr
        end
    end

endmodule

//--- rtl/fetch_stage.sv
// fetch_stage: program counter with sequential advance and redirect from execute
`timescale 1ns/1ps

module fetch_stage (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          redirect_valid_i,
    input  core_pkg::xlen_t redirect_pc_i,
    output core_pkg::xlen_t pc_o,
    output logic          fetch_valid_o
);
    import core_pkg::*;

    xlen_t pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;    // target fetched next cycle
        end else begin
            pc_q <= pc_q + XLEN'(4);
        end
    end

    assign pc_o = pc_q;

    // word on the port is wrong-path while execute redirects
    assign fetch_valid_o = !rst_i && !redirect_valid_i;

endmodule

//--- rtl/pipe_core_top.sv
// pipe_core_top: three-stage RV32I integer pipeline with fetch port and commit trace
`timescale 1ns/1ps

module pipe_core_top (
    input  logic             clk,
    input  logic             rst_i,
    output core_pkg::xlen_t  imem_addr_o,
    input  core_pkg::xlen_t  imem_data_i,
    output logic             commit_valid_o,
    output core_pkg::ex_wb_t commit_o
);
    import core_pkg::*;

    logic     fetch_valid;
    if_id_t   if_id_d;
    if_id_t   if_id_q;
    logic     if_id_valid;

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;

    id_ex_t   id_ex_d;
    logic     id_ex_d_valid;
    id_ex_t   id_ex_q;
    logic     id_ex_valid;

    ex_wb_t   ex_wb_d;
    logic     ex_wb_d_valid;

    logic     redirect_valid;
    xlen_t    redirect_pc;

    assign if_id_d.pc   = imem_addr_o;
    assign if_id_d.insn = imem_data_i;

    fetch_stage u_fetch_stage (
        .clk              (clk),
        .rst_i            (rst_i),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .pc_o             (imem_addr_o),
        .fetch_valid_o    (fetch_valid)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (redirect_valid),
        .valid_i (fetch_valid),
        .data_i  (if_id_d),
        .valid_o (if_id_valid),
        .data_o  (if_id_q)
    );

    decode_stage u_decode_stage (
        .if_id_i       (if_id_q),
        .if_id_valid_i (if_id_valid),
        .rs1_o         (rs1_idx),
        .rs2_o         (rs2_idx),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .id_ex_o       (id_ex_d),
        .id_ex_valid_o (id_ex_d_valid)
    );

    regfile u_regfile (
        .clk        (clk),
        .rs1_i      (rs1_idx),
        .rs2_i      (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (commit_valid_o && commit_o.reg_write), // write at commit
        .rd_i       (commit_o.rd),
        .wd_i       (commit_o.result)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (redirect_valid),
        .valid_i (id_ex_d_valid),
        .data_i  (id_ex_d),
        .valid_o (id_ex_valid),
        .data_o  (id_ex_q)
    );

    execute_stage u_execute_stage (
        .id_ex_i          (id_ex_q),
        .id_ex_valid_i    (id_ex_valid),
        .fwd_i            (commit_o),
        .fwd_valid_i      (commit_valid_o),
        .ex_wb_o          (ex_wb_d),
        .ex_wb_valid_o    (ex_wb_d_valid),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    // the branch itself always retires
    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (1'b0),
        .valid_i (ex_wb_d_valid),
        .data_i  (ex_wb_d),
        .valid_o (commit_valid_o),
        .data_o  (commit_o)
    );

endmodule

//--- rtl/pipe_reg.sv
// pipe_reg: stage register for any payload type, with valid bit, flush and reset
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;      // bubble carries zeros
        end else begin
            valid_o <= valid_i;
            data_o  <= data_i;
        end
    end

endmodule

//--- rtl/regfile.sv
// regfile: x1..x31 integer registers, two read ports and one write port with write-first bypass
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  core_pkg::reg_idx_t rs1_i,
    input  core_pkg::reg_idx_t rs2_i,
    output core_pkg::xlen_t   rs1_data_o,
    output core_pkg::xlen_t   rs2_data_o,
    input  logic              we_i,
    input  core_pkg::reg_idx_t rd_i,
    input  core_pkg::xlen_t   wd_i
);
    import core_pkg::*;

    xlen_t regs_q [1:31]; // no storage for x0

    always_ff @(posedge clk) begin
        if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= wd_i;
        end
    end

    always_comb begin
        if (rs1_i == '0) begin
            rs1_data_o = '0;
        end else if (we_i && rd_i == rs1_i) begin
            rs1_data_o = wd_i;       // same-cycle write wins
        end else begin
            rs1_data_o = regs_q[rs1_i];
        end
    end

    always_comb begin
        if (rs2_i == '0) begin
            rs2_data_o = '0;
        end else if (we_i && rd_i == rs2_i) begin
            rs2_data_o = wd_i;
        end else begin
            rs2_data_o = regs_q[rs2_i];
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the pipe_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module pipe_core_tb -f pipe_core_top.f -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can print its verdict
out=$(./obj_dir/Vpipe_core_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

//--- verif/commit_checker.sv
// commit_checker: ISA model of the RV32I subset that retires the program and checks every commit
`timescale 1ns/1ps

module commit_checker (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             commit_valid_i,
    input  core_pkg::ex_wb_t commit_i,
    input  core_pkg::xlen_t  imem_i [256],
    output logic             done_o,
    output int               commits_o,
    output int               errors_o
);
    import core_pkg::*;

    localparam int MAX_STEPS = 1024; // bound on the model pre-run

    xlen_t m_pc;
    xlen_t m_regs [32];
    xlen_t loop_pc;
    logic  done = 1'b0;
    int    commits = 0;
    int    exp_retired = 0;
    int    release_cycles = 0;
    int    loop_commits = 0;
    int    taken_cnt = 0;
    int    not_taken_cnt = 0;
    int    x0_reads = 0;
    int    err_stream = 0;
    int    err_reset = 0;
    int    err_flow = 0;
    int    err_x0 = 0;
    int    err_end = 0;

    assign done_o    = done;
    assign commits_o = commits;
    assign errors_o  = err_stream + err_reset + err_flow + err_x0 + err_end;

    task automatic compare_field(input string name, input xlen_t exp, input xlen_t got,
                                 inout int errs);
        if (exp !== got) begin
            errs++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic model_reset();
        m_pc = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
    endtask

    // executes the word at m_pc and returns what the core should report
    task automatic model_step(output ex_wb_t exp, output logic is_branch, output logic taken,
                              output logic reads_x0, output logic is_loop);
        xlen_t    word;
        xlen_t    a;
        xlen_t    b;
        xlen_t    res;
        xlen_t    next_pc;
        logic     writes;
        logic     unk;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word      = imem_i[m_pc[9:2]];
        rd        = word[11:7];
        rs1       = word[19:15];
        rs2       = word[24:20];
        a         = m_regs[rs1];
        b         = m_regs[rs2];
        res       = '0;
        writes    = 1'b0;
        unk       = 1'b0;
        is_branch = 1'b0;
        taken     = 1'b0;
        reads_x0  = 1'b0;
        next_pc   = m_pc + 32'd4;
        case (word[6:0])
            7'b0110011: begin
                writes   = 1'b1;
                reads_x0 = (rs1 == 5'd0) || (rs2 == 5'd0);
                case ({word[31:25], word[14:12]})
                    10'b0000000_000: res = a + b;
                    10'b0100000_000: res = a - b;
                    10'b0000000_111: res = a & b;
                    10'b0000000_110: res = a | b;
                    10'b0000000_100: res = a ^ b;
                    10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: begin
                        writes = 1'b0;
                        unk    = 1'b1;
                    end
                endcase
            end
            7'b0010011: begin
                if (word[14:12] == 3'b000) begin   // addi
                    writes   = 1'b1;
                    reads_x0 = (rs1 == 5'd0);
                    res      = a + {{20{word[31]}}, word[31:20]};
                end else begin
                    unk = 1'b1;
                end
            end
            7'b0110111: begin   // lui
                writes = 1'b1;
                res    = {word[31:12], 12'h000};
            end
            7'b1100011: begin
                if (word[14:13] == 2'b00) begin   // beq when bit 12 clear
                    is_branch = 1'b1;
                    reads_x0  = (rs1 == 5'd0) || (rs2 == 5'd0);
                    taken     = (a == b) ^ word[12];
                    if (taken) begin
                        next_pc = m_pc + {{19{word[31]}}, word[31], word[7], word[30:25],
                                          word[11:8], 1'b0};
                    end
                end else begin
                    unk = 1'b1;
                end
            end
            7'b1101111: begin   // jal links pc+4
                writes  = 1'b1;
                taken   = 1'b1;
                res     = m_pc + 32'd4;
                next_pc = m_pc + {{11{word[31]}}, word[31], word[19:12], word[20],
                                  word[30:21], 1'b0};
            end
            default: unk = 1'b1;
        endcase
        writes        = writes && (rd != 5'd0);
        is_loop       = taken && (next_pc == m_pc);
        exp           = '0;
        exp.pc        = m_pc;
        exp.rd        = writes ? rd : 5'd0;
        exp.reg_write = writes;
        exp.result    = writes ? res : '0;
        exp.unknown   = unk;
        if (writes) begin
            m_regs[rd] = res;
        end
        m_pc = next_pc;
    endtask

    // counts retirements up to and including the first self-loop, and notes its pc
    task automatic model_prerun();
        ex_wb_t exp;
        logic   is_branch;
        logic   taken;
        logic   reads_x0;
        logic   is_loop;
        model_reset();
        exp_retired = 0;
        loop_pc     = '1;   // unreachable until the loop is found
        is_loop     = 1'b0;
        while (!is_loop && exp_retired < MAX_STEPS) begin
            model_step(exp, is_branch, taken, reads_x0, is_loop);
            exp_retired++;
            if (is_loop) begin
                loop_pc = exp.pc;
            end
        end
        model_reset();
    endtask

    task automatic finish_tests();
        done = 1'b1;
        $display("test 1 commit stream: %0d commits checked, %0d errors", commits, err_stream);
        $display("test 3 control flow: %0d taken, %0d not taken, %0d errors",
                 taken_cnt, not_taken_cnt, err_flow);
        $display("test 4 x0 stays zero: %0d reads of x0, %0d errors", x0_reads, err_x0);
        $display("test 5 termination: self-loop after %0d commits, %0d errors",
                 exp_retired, err_end);
    endtask

    task automatic check_commit();
        ex_wb_t exp;
        logic   is_branch;
        logic   taken;
        logic   reads_x0;
        logic   is_loop;
        commits++;
        if (commits == 1) begin
            if (release_cycles != 3) begin
                err_reset++;
                $display("first commit came %0d cycles after reset release instead of 3",
                         release_cycles);
            end
            compare_field("commit_o.pc (first)", RESET_PC, commit_i.pc, err_reset);
            $display("test 2 reset and first commit: %0d errors", err_reset);
        end
        model_step(exp, is_branch, taken, reads_x0, is_loop);
        compare_field("commit_o.pc", exp.pc, commit_i.pc, err_flow);
        if (is_branch) begin
            compare_field("commit_o.rd", xlen_t'(exp.rd), xlen_t'(commit_i.rd), err_flow);
            compare_field("commit_o.reg_write", xlen_t'(exp.reg_write),
                          xlen_t'(commit_i.reg_write), err_flow);
        end else begin
            compare_field("commit_o.rd", xlen_t'(exp.rd), xlen_t'(commit_i.rd), err_stream);
            compare_field("commit_o.reg_write", xlen_t'(exp.reg_write),
                          xlen_t'(commit_i.reg_write), err_stream);
        end
        compare_field("commit_o.unknown", xlen_t'(exp.unknown), xlen_t'(commit_i.unknown),
                      err_stream);
        if (exp.reg_write && reads_x0) begin
            compare_field("commit_o.result", exp.result, commit_i.result, err_x0);
        end else if (exp.reg_write) begin
            compare_field("commit_o.result", exp.result, commit_i.result, err_stream);
        end
        if (taken) taken_cnt++;
        if (is_branch && !taken) not_taken_cnt++;
        if (reads_x0) x0_reads++;
        // the core's own arrival at the loop pc ends the run
        if (commit_i.pc == loop_pc) begin
            loop_commits++;
            if (loop_commits == 1 && commits != exp_retired) begin
                err_end++;
                $display("core retired %0d instructions up to the self-loop, model retired %0d",
                         commits, exp_retired);
            end
            if (loop_commits == 2) begin
                finish_tests();
            end
        end
    endtask

    // outputs come from flops, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst_i) begin
            if (commit_valid_i !== 1'b0) begin
                err_reset++;
                $display("mismatch at %0t: commit_valid_o expected 0 got %b",
                         $time, commit_valid_i);
            end
            model_prerun();
            release_cycles = 0;
        end else begin
            if (commit_valid_i && !done) begin
                check_commit();
            end
            release_cycles++;
        end
    end

endmodule

//--- verif/pipe_core_props.sv
// pipe_core_props: concurrent assertions on the commit trace and redirect timing of the core
`timescale 1ns/1ps

module pipe_core_props (
    input logic             clk,
    input logic             rst_i,
    input logic             redirect_valid_i,
    input logic             commit_valid_i,
    input core_pkg::ex_wb_t commit_i
);

    int fail_count = 0; // assertion failures so far

    // nothing retires while the core is held in reset
    reset_quiet: assert property (@(posedge clk) rst_i |=> !commit_valid_i)
        else begin
            fail_count++;
            $error("commit_valid_o was high while rst_i was asserted");
        end

    // branch retires next, then two empty slots before the target retires
    redirect_gap: assert property (@(posedge clk) disable iff (rst_i)
        redirect_valid_i |=> commit_valid_i ##1 !commit_valid_i ##1 !commit_valid_i
                             ##1 commit_valid_i)
        else begin
            fail_count++;
            $error("commit spacing after a taken redirect was not a two-cycle gap");
        end

    x0_no_write: assert property (@(posedge clk) disable iff (rst_i)
        commit_valid_i && (commit_i.rd == 5'd0) |-> !commit_i.reg_write)
        else begin
            fail_count++;
            $error("a commit with rd zero had reg_write set");
        end

endmodule

bind pipe_core_top pipe_core_props u_props (
    .clk              (clk),
    .rst_i            (rst_i),
    .redirect_valid_i (redirect_valid),
    .commit_valid_i   (commit_valid_o),
    .commit_i         (commit_o)
);

//--- verif/pipe_core_tb.sv
// pipe_core_tb: random RV32I program in instruction memory, clock, reset, timeout and report
`timescale 1ns/1ps

module pipe_core_tb;
    import core_pkg::*;

    localparam int IMEM_WORDS     = 256;
    localparam int PROG_LEN       = 200;
    localparam int TIMEOUT_CYCLES = 3 * PROG_LEN + 50;

    logic        clk;
    logic        rst_i;
    xlen_t       imem_addr;
    xlen_t       imem_data;
    logic        commit_valid;
    ex_wb_t      commit;
    xlen_t       imem [IMEM_WORDS];
    logic [31:0] rng_state;
    logic        done;
    int          commits;
    int          check_errors;
    int          cycle_cnt;
    logic        timed_out;

    always #10 clk = ~clk;

    assign imem_data = imem[imem_addr[9:2]]; // combinational fetch

    pipe_core_top pipe_core_top_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .commit_valid_o (commit_valid),
        .commit_o       (commit)
    );

    commit_checker u_checker (
        .clk            (clk),
        .rst_i          (rst_i),
        .commit_valid_i (commit_valid),
        .commit_i       (commit),
        .imem_i         (imem),
        .done_o         (done),
        .commits_o      (commits),
        .errors_o       (check_errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic reg_idx_t rand_reg();
        logic [31:0] r;
        r = next_random();
        return {2'b00, r[2:0]};   // x0..x7
    endfunction

    // forward distance in words, clamped so the target stays inside the program
    function automatic int fwd_words(input int idx);
        int off;
        off = 1 + int'(next_random() % 32'd4);
        if (idx + off > PROG_LEN - 1) off = PROG_LEN - 1 - idx;
        return off;
    endfunction

    function automatic xlen_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic xlen_t enc_addi(input reg_idx_t rd, input reg_idx_t rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic xlen_t enc_lui(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic xlen_t enc_branch(input logic bne, input reg_idx_t rs1,
                                         input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic xlen_t enc_jal(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic xlen_t random_alu();
        logic [9:0] f;
        case (next_random() % 32'd6)
            0:       f = {7'h00, 3'b000};   // add
            1:       f = {7'h20, 3'b000};   // sub
            2:       f = {7'h00, 3'b111};   // and
            3:       f = {7'h00, 3'b110};   // or
            4:       f = {7'h00, 3'b100};   // xor
            default: f = {7'h00, 3'b010};   // slt
        endcase
        return enc_r(f[9:3], f[2:0], rand_reg(), rand_reg(), rand_reg());
    endfunction

    task automatic generate_program();
        logic [31:0] r;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'hbad0_0000 ^ (xlen_t'(i) << 2);
        end
        // give x1..x7 defined values first
        for (int i = 1; i < 8; i++) begin
            r           = next_random();
            imem[i - 1] = enc_addi(reg_idx_t'(i), 5'd0, r[11:0]);
        end
        for (int i = 7; i < PROG_LEN - 1; i++) begin
            r = next_random();
            case (r % 32'd10)
                0, 1, 2, 3: imem[i] = random_alu();
                4, 5:       imem[i] = enc_addi(rand_reg(), rand_reg(), r[31:20]);
                6:          imem[i] = enc_lui(rand_reg(), r[31:12]);
                7, 8:       imem[i] = enc_branch(r[16], rand_reg(), rand_reg(),
                                                 13'(fwd_words(i) * 4));
                default:    imem[i] = enc_jal(rand_reg(), 21'(fwd_words(i) * 4));
            endcase
        end
        imem[PROG_LEN - 1] = enc_jal(5'd0, 21'd0);   // self-loop
    endtask

    initial begin
        clk       = 1'b0;
        rst_i     = 1'b1;
        rng_state = 32'h489a_516c;
        timed_out = 1'b0;
        cycle_cnt = 0;
        generate_program();
        repeat (4) @(posedge clk);
        #1 rst_i = 1'b0;
        while (!done && cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        if (!done) begin
            timed_out = 1'b1;
            $display("timeout: the program did not reach its self-loop within %0d cycles",
                     TIMEOUT_CYCLES);
        end
        $display("summary: %0d commits, %0d check errors, %0d assertion failures",
                 commits, check_errors, pipe_core_top_i.u_props.fail_count);
        if (!timed_out && check_errors == 0 && pipe_core_top_i.u_props.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
